/* all.f */
+incdir+source
source/noc_link_pkg.sv
source/two_elem_fifo.sv
source/repeater_node.sv
source/link_port.sv
source/link_regs_apb.sv
source/noc_link_bridge.sv
verification/link_checker.sv
verification/tb_noc_link_bridge.sv

/* run.sh */
#!/bin/sh
# Compile and run the NoC link bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f all.f \
  --top-module tb_noc_link_bridge -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

# The verdict comes from the log alone
if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* source/link_port.sv */
/* Ingress link port at one end of the repeater chain
   Gates new flits with a registered enable and flags each accepted flit */

`default_nettype none

module link_port (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire logic           enable_i,
  input  wire logic           src_valid_i,
  input  noc_link_pkg::flit_t src_data_i,
  output logic                src_ready_o,
  output logic                dst_valid_o,
  output noc_link_pkg::flit_t dst_data_o,
  input  wire logic           dst_ready_i,
  output logic                accept_o
);

  // Local copy of the enable, so a register write lands one cycle later
  logic en_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q <= 1'b0;
    end else begin
      en_q <= enable_i;
    end
  end

  // While disabled both halves of the handshake are forced low
  // so no flit can enter and the source just keeps holding its word
  assign src_ready_o = en_q & dst_ready_i;
  assign dst_valid_o = en_q & src_valid_i;

  // Payload goes through untouched, there is no added latency here
  assign dst_data_o = src_data_i;

  // One pulse per completed ingress transfer, feeds the flit counter
  assign accept_o = src_valid_i & src_ready_o;

endmodule

`default_nettype wire

/* source/link_regs_apb.sv */
/* APB register block for the link bridge
   Holds the link enable and two saturating accepted-flit counters */

`default_nettype none

`include "noc_link_params.svh"

module link_regs_apb (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 psel_i,
  input  wire logic                 penable_i,
  input  wire logic                 pwrite_i,
  input  noc_link_pkg::apb_addr_t   paddr_i,
  input  noc_link_pkg::apb_data_t   pwdata_i,
  output noc_link_pkg::apb_data_t   prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  input  wire logic                 inc_ab_i,
  input  wire logic                 inc_ba_i,
  output logic                      enable_o
);

  import noc_link_pkg::*;

  logic                      en_q;
  logic [`NOC_CNT_WIDTH-1:0] cnt_ab_q;
  logic [`NOC_CNT_WIDTH-1:0] cnt_ba_q;
  logic                      sel_ctrl;
  logic                      sel_ab;
  logic                      sel_ba;
  logic                      mapped;
  logic                      wr_en;
  apb_data_t                 rd_mux;

  // Next counter value, a clear beats an increment landing in the same cycle
  function automatic logic [`NOC_CNT_WIDTH-1:0] cnt_next(
    input logic [`NOC_CNT_WIDTH-1:0] cnt,
    input logic                      clr,
    input logic                      inc
  );
    logic [`NOC_CNT_WIDTH-1:0] nxt;
    nxt = cnt;
    if (clr) begin
      nxt = '0;
    end else if (inc && (cnt != '1)) begin
      // Sticks at all ones instead of wrapping back to zero
      nxt = cnt + 1'b1;
    end
    return nxt;
  endfunction

  // Address decode against the full offset
  assign sel_ctrl = (paddr_i == REG_CTRL);
  assign sel_ab   = (paddr_i == REG_CNT_AB);
  assign sel_ba   = (paddr_i == REG_CNT_BA);
  assign mapped   = sel_ctrl | sel_ab | sel_ba;

  // No wait states, so writes commit at the edge ending the access phase
  assign wr_en     = psel_i & penable_i & pwrite_i;
  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i & penable_i & ~mapped;

  always_comb begin
    rd_mux = '0;
    if (sel_ctrl) begin
      rd_mux[CTRL_EN_BIT] = en_q;
    end else if (sel_ab) begin
      rd_mux = apb_data_t'(cnt_ab_q);
    end else if (sel_ba) begin
      rd_mux = apb_data_t'(cnt_ba_q);
    end
  end

  // Read data only shows while a read is selected, zero otherwise
  assign prdata_o = (psel_i && !pwrite_i) ? rd_mux : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q     <= 1'b0;
      cnt_ab_q <= '0;
      cnt_ba_q <= '0;
    end else begin
      if (wr_en && sel_ctrl) begin
        en_q <= pwdata_i[CTRL_EN_BIT];
      end
      // Any write to a counter clears it whatever the data
      cnt_ab_q <= cnt_next(cnt_ab_q, wr_en & sel_ab, inc_ab_i);
      cnt_ba_q <= cnt_next(cnt_ba_q, wr_en & sel_ba, inc_ba_i);
    end
  end

  assign enable_o = en_q;

endmodule

`default_nettype wire

/* source/noc_link_bridge.sv */
/* Bidirectional NoC link bridge for long on-chip routes
   Link ports at both ends, a chain of repeater nodes and APB registers */

`default_nettype none

`include "noc_link_params.svh"

module noc_link_bridge (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               a_valid_i,
  input  noc_link_pkg::flit_t     a_data_i,
  output logic                    a_ready_o,
  output logic                    a_valid_o,
  output noc_link_pkg::flit_t     a_data_o,
  input  wire logic               a_ready_i,
  input  wire logic               b_valid_i,
  input  noc_link_pkg::flit_t     b_data_i,
  output logic                    b_ready_o,
  output logic                    b_valid_o,
  output noc_link_pkg::flit_t     b_data_o,
  input  wire logic               b_ready_i,
  input  wire logic               psel_i,
  input  wire logic               penable_i,
  input  wire logic               pwrite_i,
  input  noc_link_pkg::apb_addr_t paddr_i,
  input  noc_link_pkg::apb_data_t pwdata_i,
  output noc_link_pkg::apb_data_t prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  import noc_link_pkg::*;

  localparam int unsigned NODES = `NOC_NUM_NODES;

  // Segment k sits in front of node k, segment NODES is the far end
  // The A-to-B lane runs upward in index, the B-to-A lane runs downward
  logic  ab_valid [NODES+1];
  flit_t ab_data  [NODES+1];
  logic  ab_ready [NODES+1];
  logic  ba_valid [NODES+1];
  flit_t ba_data  [NODES+1];
  logic  ba_ready [NODES+1];
  logic  inc_ab;
  logic  inc_ba;
  logic  link_en;

  // Side A ingress feeds segment 0 of the A-to-B lane
  link_port u_port_a (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .enable_i (link_en),
    .src_valid_i (a_valid_i), .src_data_i (a_data_i), .src_ready_o (a_ready_o),
    .dst_valid_o (ab_valid[0]), .dst_data_o (ab_data[0]), .dst_ready_i (ab_ready[0]),
    .accept_o (inc_ab)
  );

  // Side B ingress feeds the far segment of the B-to-A lane
  link_port u_port_b (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .enable_i (link_en),
    .src_valid_i (b_valid_i), .src_data_i (b_data_i), .src_ready_o (b_ready_o),
    .dst_valid_o (ba_valid[NODES]), .dst_data_o (ba_data[NODES]),
    .dst_ready_i (ba_ready[NODES]), .accept_o (inc_ba)
  );

  for (genvar k = 0; k < NODES; k++) begin : g_node
    repeater_node u_node (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .ab_valid_i (ab_valid[k]), .ab_data_i (ab_data[k]), .ab_ready_o (ab_ready[k]),
      .ab_valid_o (ab_valid[k+1]), .ab_data_o (ab_data[k+1]), .ab_ready_i (ab_ready[k+1]),
      .ba_valid_i (ba_valid[k+1]), .ba_data_i (ba_data[k+1]), .ba_ready_o (ba_ready[k+1]),
      .ba_valid_o (ba_valid[k]), .ba_data_o (ba_data[k]), .ba_ready_i (ba_ready[k])
    );
  end

  // Egress on both sides comes straight off the end nodes
  assign b_valid_o       = ab_valid[NODES];
  assign b_data_o        = ab_data[NODES];
  assign ab_ready[NODES] = b_ready_i;
  assign a_valid_o       = ba_valid[0];
  assign a_data_o        = ba_data[0];
  assign ba_ready[0]     = a_ready_i;

  link_regs_apb u_regs (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
    .pready_o (pready_o), .pslverr_o (pslverr_o),
    .inc_ab_i (inc_ab), .inc_ba_i (inc_ba), .enable_o (link_en)
  );

endmodule

`default_nettype wire

/* source/noc_link_params.svh */
/* NoC link bridge build parameters
   Flit width, chain depth, counter width and APB address width */

`ifndef NOC_LINK_PARAMS_SVH
`define NOC_LINK_PARAMS_SVH

// Bits carried by one flit on either lane
`define NOC_FLIT_WIDTH 32

// Repeater nodes between the two link ports, one cycle of latency each
`define NOC_NUM_NODES 3

// Width of the saturating accepted-flit counters
`define NOC_CNT_WIDTH 32

// APB address bits seen by the register block
`define NOC_APB_AW 8

`endif

/* source/noc_link_pkg.sv */
/* NoC link bridge shared types
   Flit payload, APB address and data words, register map offsets */

`default_nettype none

`include "noc_link_params.svh"

package noc_link_pkg;

  // One flit is a plain payload word, the bridge never looks inside it
  typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

  // APB address as decoded by the register block
  typedef logic [`NOC_APB_AW-1:0] apb_addr_t;

  // APB read and write data are always a full 32-bit word
  typedef logic [31:0] apb_data_t;

  // Control register, bit 0 enables both ingress ports
  localparam apb_addr_t REG_CTRL = apb_addr_t'('h0);

  // Flits accepted at side A, any write clears it
  localparam apb_addr_t REG_CNT_AB = apb_addr_t'('h4);

  // Flits accepted at side B, any write clears it
  localparam apb_addr_t REG_CNT_BA = apb_addr_t'('h8);

  // Position of the enable inside REG_CTRL
  localparam int unsigned CTRL_EN_BIT = 0;

endpackage

`default_nettype wire

/* source/repeater_node.sv */
/* Repeater node for a long bidirectional route
   One registered FIFO stage per lane, A-to-B and B-to-A */

`default_nettype none

module repeater_node (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire logic          ab_valid_i,
  input  noc_link_pkg::flit_t ab_data_i,
  output logic               ab_ready_o,
  output logic               ab_valid_o,
  output noc_link_pkg::flit_t ab_data_o,
  input  wire logic          ab_ready_i,
  input  wire logic          ba_valid_i,
  input  noc_link_pkg::flit_t ba_data_i,
  output logic               ba_ready_o,
  output logic               ba_valid_o,
  output noc_link_pkg::flit_t ba_data_o,
  input  wire logic          ba_ready_i
);

  import noc_link_pkg::*;

  // Lane from side A towards side B
  two_elem_fifo #(.payload_t(flit_t)) u_fifo_ab (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ab_valid_i),
    .data_i  (ab_data_i),
    .ready_o (ab_ready_o),
    .valid_o (ab_valid_o),
    .data_o  (ab_data_o),
    .ready_i (ab_ready_i)
  );

  // Lane from side B towards side A, the mirror of the one above
  two_elem_fifo #(.payload_t(flit_t)) u_fifo_ba (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ba_valid_i),
    .data_i  (ba_data_i),
    .ready_o (ba_ready_o),
    .valid_o (ba_valid_o),
    .data_o  (ba_data_o),
    .ready_i (ba_ready_i)
  );

endmodule

`default_nettype wire

/* source/two_elem_fifo.sv */
/* Two-entry FIFO with valid/ready on both sides
   Both ready_o and valid_o come from flops, one flit per cycle sustained */

`default_nettype none

module two_elem_fifo #(
  parameter type payload_t = noc_link_pkg::flit_t
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic valid_i,
  input  payload_t  data_i,
  output logic      ready_o,
  output logic      valid_o,
  output payload_t  data_o,
  input  wire logic ready_i
);

  // Payload slots are written at wr_ptr_q and read at rd_ptr_q
  payload_t mem_q [2];
  logic     wr_ptr_q;
  logic     rd_ptr_q;
  logic     full_q;
  logic     empty_q;
  logic     enq;
  logic     deq;

  // A transfer happens on each side only when both halves of the handshake are up
  assign enq = valid_i & ~full_q;
  assign deq = ready_i & ~empty_q;

  // Outputs are straight from state so no combinational path crosses the FIFO
  assign ready_o = ~full_q;
  assign valid_o = ~empty_q;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (enq) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (deq) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Occupancy only changes when exactly one side moves
      if (enq && !deq) begin
        empty_q <= 1'b0;
        full_q  <= (~wr_ptr_q == rd_ptr_q);
      end else if (deq && !enq) begin
        full_q  <= 1'b0;
        empty_q <= (~rd_ptr_q == wr_ptr_q);
      end
    end
  end

endmodule

`default_nettype wire

/* verification/link_checker.sv */
/* Link bridge checker
   Queue model per direction that compares egress flits and reported values */

`default_nettype none

module link_checker (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire logic           a_in_valid_i,
  input  noc_link_pkg::flit_t a_in_data_i,
  input  wire logic           a_in_ready_i,
  input  wire logic           a_out_valid_i,
  input  noc_link_pkg::flit_t a_out_data_i,
  input  wire logic           a_out_ready_i,
  input  wire logic           b_in_valid_i,
  input  noc_link_pkg::flit_t b_in_data_i,
  input  wire logic           b_in_ready_i,
  input  wire logic           b_out_valid_i,
  input  noc_link_pkg::flit_t b_out_data_i,
  input  wire logic           b_out_ready_i,
  output int                  ab_in_cnt_o,
  output int                  ba_in_cnt_o,
  output int                  ab_pend_o,
  output int                  ba_pend_o,
  output int                  err_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import noc_link_pkg::*;

  // Flits accepted at one side and not yet seen leaving the other
  flit_t q_ab [$];
  flit_t q_ba [$];
  flit_t exp_flit;
  int    flit_errs;
  int    value_errs;
  string cur_test = "none";

  assign err_cnt_o = flit_errs + value_errs;

  // Name used in every error line until the next test starts
  task automatic start_test(input string name);
    cur_test = name;
  endtask

  // Compares one value that the testbench read back from the DUT
  task automatic expect_value(input string what, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      value_errs++;
      $display("mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp_val, act_val);
    end
  endtask

  // Handshakes are sampled at the rising edge where they complete
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (a_in_valid_i && a_in_ready_i) begin
        q_ab.push_back(a_in_data_i);
        ab_in_cnt_o++;
      end
      if (b_in_valid_i && b_in_ready_i) begin
        q_ba.push_back(b_in_data_i);
        ba_in_cnt_o++;
      end
      // Egress at side B must match the oldest flit that entered at side A
      if (b_out_valid_i && b_out_ready_i) begin
        if (q_ab.size() == 0) begin
          flit_errs++;
          $display("error in %s: a flit left side B with no flit in flight from side A",
                   cur_test);
        end else begin
          exp_flit = q_ab.pop_front();
          if (exp_flit !== b_out_data_i) begin
            flit_errs++;
            $display("mismatch in %s (flit at side B): expected %h, actual %h",
                     cur_test, exp_flit, b_out_data_i);
          end
        end
      end
      // And the mirror lane towards side A
      if (a_out_valid_i && a_out_ready_i) begin
        if (q_ba.size() == 0) begin
          flit_errs++;
          $display("error in %s: a flit left side A with no flit in flight from side B",
                   cur_test);
        end else begin
          exp_flit = q_ba.pop_front();
          if (exp_flit !== a_out_data_i) begin
            flit_errs++;
            $display("mismatch in %s (flit at side A): expected %h, actual %h",
                     cur_test, exp_flit, a_out_data_i);
          end
        end
      end
      ab_pend_o = q_ab.size();
      ba_pend_o = q_ba.size();
    end
  end

endmodule

`default_nettype wire

/* verification/tb_noc_link_bridge.sv */
/* Testbench for the NoC link bridge
   Random flits both ways, APB register access, latency and link disable */

`default_nettype none

`include "noc_link_params.svh"

module tb_noc_link_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  import noc_link_pkg::*;

  localparam int NUM_FLITS     = 500;
  localparam int WAIT_LIMIT    = 200;
  localparam int TRAFFIC_LIMIT = 20000;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      a_valid_i;
  flit_t     a_data_i;
  logic      a_ready_o;
  logic      a_valid_o;
  flit_t     a_data_o;
  logic      a_ready_i;
  logic      b_valid_i;
  flit_t     b_data_i;
  logic      b_ready_o;
  logic      b_valid_o;
  flit_t     b_data_o;
  logic      b_ready_i;
  logic      psel_i;
  logic      penable_i;
  logic      pwrite_i;
  apb_addr_t paddr_i;
  apb_data_t pwdata_i;
  apb_data_t prdata_o;
  logic      pready_o;
  logic      pslverr_o;
  int        ab_in_cnt;
  int        ba_in_cnt;
  int        ab_pend;
  int        ba_pend;
  int        err_cnt;
  int        timeouts;
  int        tests_run;
  int        tests_failed;
  int        faults_at_start;
  int        base_ab;
  int        base_ba;
  int        lat;
  string     test_name;
  apb_data_t rdata;
  int        exp_cnt_ab;
  int        exp_cnt_ba;
  logic      rerr;
  logic      seen_ready;

  noc_link_bridge u_dut (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .a_valid_i (a_valid_i), .a_data_i (a_data_i), .a_ready_o (a_ready_o),
    .a_valid_o (a_valid_o), .a_data_o (a_data_o), .a_ready_i (a_ready_i),
    .b_valid_i (b_valid_i), .b_data_i (b_data_i), .b_ready_o (b_ready_o),
    .b_valid_o (b_valid_o), .b_data_o (b_data_o), .b_ready_i (b_ready_i),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
    .pready_o (pready_o), .pslverr_o (pslverr_o)
  );

  // Ingress of one side pairs with egress of the other inside the checker
  link_checker u_checker (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .a_in_valid_i (a_valid_i), .a_in_data_i (a_data_i), .a_in_ready_i (a_ready_o),
    .a_out_valid_i (a_valid_o), .a_out_data_i (a_data_o), .a_out_ready_i (a_ready_i),
    .b_in_valid_i (b_valid_i), .b_in_data_i (b_data_i), .b_in_ready_i (b_ready_o),
    .b_out_valid_i (b_valid_o), .b_out_data_i (b_data_o), .b_out_ready_i (b_ready_i),
    .ab_in_cnt_o (ab_in_cnt), .ba_in_cnt_o (ba_in_cnt),
    .ab_pend_o (ab_pend), .ba_pend_o (ba_pend), .err_cnt_o (err_cnt)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  function automatic int fault_count();
    return err_cnt + timeouts;
  endfunction

  task automatic timeout_hit(input string what);
    timeouts++;
    $display("error in %s: timed out waiting for %s", test_name, what);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    u_checker.start_test(name);
    faults_at_start = fault_count();
    tests_run++;
  endtask

  task automatic end_test();
    if (fault_count() != faults_at_start) begin
      tests_failed++;
      $display("test %s: failed", test_name);
    end else begin
      $display("test %s: passed", test_name);
    end
  endtask

  // Setup phase on one falling edge, access phase until pready at a rising edge
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rd, output logic err);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    rd = '0;
    err = 1'b0;
    @(negedge clk_i);
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = wr;
    paddr_i = addr;
    pwdata_i = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    while (!done && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      done = pready_o;
      rd = prdata_o;
      err = pslverr_o;
      n++;
    end
    if (!done) begin
      timeout_hit("APB pready");
    end
    @(negedge clk_i);
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, addr, wdata, rd, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t rd, output logic err);
    apb_access(1'b0, addr, '0, rd, err);
  endtask

  // Random sources on both sides with random egress back-pressure
  // A source holds valid and data until the rising edge that takes the flit
  task automatic run_traffic(input int n);
    int   a_left;
    int   b_left;
    int   cycles;
    logic a_fire;
    logic b_fire;
    a_left = n;
    b_left = n;
    cycles = 0;
    while ((a_left > 0 || b_left > 0 || a_valid_i || b_valid_i) && cycles < TRAFFIC_LIMIT) begin
      @(posedge clk_i);
      a_fire = a_valid_i & a_ready_o;
      b_fire = b_valid_i & b_ready_o;
      @(negedge clk_i);
      if (!a_valid_i || a_fire) begin
        a_valid_i = (a_left > 0) && ($urandom_range(3) != 0);
        if (a_valid_i) begin
          a_data_i = flit_t'($urandom);
          a_left--;
        end
      end
      if (!b_valid_i || b_fire) begin
        b_valid_i = (b_left > 0) && ($urandom_range(3) != 0);
        if (b_valid_i) begin
          b_data_i = flit_t'($urandom);
          b_left--;
        end
      end
      a_ready_i = ($urandom_range(2) != 0);
      b_ready_i = ($urandom_range(2) != 0);
      cycles++;
    end
    if (cycles >= TRAFFIC_LIMIT) begin
      timeout_hit("the random flits to be accepted");
    end
  endtask

  // Waits until every flit in flight has left the chain
  task automatic wait_drained();
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while ((ab_pend != 0 || ba_pend != 0) && n < WAIT_LIMIT);
    if (ab_pend != 0 || ba_pend != 0) begin
      timeout_hit("the repeater chain to drain");
    end
  endtask

  task automatic send_a(input flit_t d);
    int   n;
    logic fired;
    n = 0;
    fired = 1'b0;
    @(negedge clk_i);
    a_valid_i = 1'b1;
    a_data_i = d;
    while (!fired && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      fired = a_ready_o;
      n++;
    end
    if (!fired) begin
      timeout_hit("side A to accept a flit");
    end
    @(negedge clk_i);
    a_valid_i = 1'b0;
  endtask

  // Counts rising edges from the ingress transfer to valid at side B
  task automatic measure_latency(input flit_t d, output int cycles);
    logic seen;
    seen = 1'b0;
    cycles = 0;
    send_a(d);
    while (!seen && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
      seen = b_valid_o;
    end
    if (!seen) begin
      timeout_hit("the flit to reach side B");
    end
  endtask

  initial begin
    void'($urandom(32'h5df85969));
    rst_n_i = 1'b0;
    a_valid_i = 1'b0;
    a_data_i = '0;
    a_ready_i = 1'b0;
    b_valid_i = 1'b0;
    b_data_i = '0;
    b_ready_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    timeouts = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "reset";
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    begin_test("reset_state");
    u_checker.expect_value("a_ready_o", 32'd0, 32'(a_ready_o));
    u_checker.expect_value("b_ready_o", 32'd0, 32'(b_ready_o));
    u_checker.expect_value("a_valid_o", 32'd0, 32'(a_valid_o));
    u_checker.expect_value("b_valid_o", 32'd0, 32'(b_valid_o));
    apb_read(REG_CTRL, rdata, rerr);
    u_checker.expect_value("REG_CTRL", 32'd0, rdata);
    u_checker.expect_value("pslverr_o on REG_CTRL", 32'd0, 32'(rerr));
    end_test();

    begin_test("random_traffic");
    apb_write(REG_CTRL, 32'h1);
    run_traffic(NUM_FLITS);
    a_ready_i = 1'b1;
    b_ready_i = 1'b1;
    wait_drained();
    u_checker.expect_value("flits accepted at side A", NUM_FLITS, ab_in_cnt);
    u_checker.expect_value("flits accepted at side B", NUM_FLITS, ba_in_cnt);
    u_checker.expect_value("flits left from A to B", 32'd0, ab_pend);
    u_checker.expect_value("flits left from B to A", 32'd0, ba_pend);
    end_test();

    begin_test("counters");
    apb_read(REG_CNT_AB, rdata, rerr);
    u_checker.expect_value("REG_CNT_AB", ab_in_cnt, rdata);
    apb_read(REG_CNT_BA, rdata, rerr);
    u_checker.expect_value("REG_CNT_BA", ba_in_cnt, rdata);
    // Any data clears a counter
    apb_write(REG_CNT_AB, 32'hffff_ffff);
    apb_write(REG_CNT_BA, 32'h1234_5678);
    base_ab = ab_in_cnt;
    base_ba = ba_in_cnt;
    apb_read(REG_CNT_AB, rdata, rerr);
    u_checker.expect_value("REG_CNT_AB after clear", 32'd0, rdata);
    apb_read(REG_CNT_BA, rdata, rerr);
    u_checker.expect_value("REG_CNT_BA after clear", 32'd0, rdata);
    end_test();

    begin_test("latency");
    measure_latency(flit_t'($urandom), lat);
    u_checker.expect_value("cycles to side B", `NOC_NUM_NODES, lat);
    wait_drained();
    end_test();

    begin_test("disable_drain");
    b_ready_i = 1'b0;
    repeat (3) send_a(flit_t'($urandom));
    apb_write(REG_CTRL, 32'h0);
    // Counts since the clear, frozen from here on while the link is off
    exp_cnt_ab = ab_in_cnt - base_ab;
    exp_cnt_ba = ba_in_cnt - base_ba;
    // The ports see the cleared enable one cycle after the write
    apb_read(REG_CNT_AB, rdata, rerr);
    u_checker.expect_value("REG_CNT_AB after disable", exp_cnt_ab, rdata);
    apb_read(REG_CNT_BA, rdata, rerr);
    u_checker.expect_value("REG_CNT_BA after disable", exp_cnt_ba, rdata);
    a_valid_i = 1'b1;
    a_data_i = flit_t'($urandom);
    b_valid_i = 1'b1;
    b_data_i = flit_t'($urandom);
    seen_ready = 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk_i);
      seen_ready = seen_ready | a_ready_o | b_ready_o;
    end
    u_checker.expect_value("ingress ready while disabled", 32'd0, 32'(seen_ready));
    @(negedge clk_i);
    b_ready_i = 1'b1;
    wait_drained();
    a_valid_i = 1'b0;
    b_valid_i = 1'b0;
    apb_read(REG_CNT_AB, rdata, rerr);
    u_checker.expect_value("REG_CNT_AB after drain", exp_cnt_ab, rdata);
    apb_read(REG_CNT_BA, rdata, rerr);
    u_checker.expect_value("REG_CNT_BA after drain", exp_cnt_ba, rdata);
    end_test();

    begin_test("unmapped_address");
    apb_read(apb_addr_t'('hC), rdata, rerr);
    u_checker.expect_value("pslverr_o", 32'd1, 32'(rerr));
    end_test();

    $display("tests run %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, err_cnt, timeouts);
    if (tests_failed == 0 && fault_count() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
